// ==== Bender.yml ====
package:
  name: bcfg

sources:
  - include_dirs:
      - include
    files:
      - hw/bus_pkg.sv
      - hw/board_pkg.sv
      - hw/quad_buffer.sv
      - hw/io_sampler.sv
      - hw/boot_config.sv
      - hw/bcfg_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_bcfg.sv

// ==== hw/bcfg_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bcfg_cfg.svh"

// boot configuration subsystem, register bus side
module bcfg_top
    import bus_pkg::*;
    import board_pkg::*;
(
    input  wire                sysclk,
    input  wire                rst_n,

    input  wire   board_id_t   wenid,         // rotary switch
    input  wire                is_v30,

    input  wire   io1_t        io1_in,
    output io1_t               io1_out,
    output io1_t               io1_oe,
    input  wire   io2_t        io2_in,
    output io2_t               io2_out,
    output io2_t               io2_oe,

    // host register bus
    input  wire   reg_addr_t   reg_raddr,
    input  wire   reg_addr_t   reg_waddr,
    input  wire   quad_t       reg_wdata,
    input  wire                reg_wen,
    input  wire                blk_wen,
    input  wire                blk_wstart,
    output quad_t              reg_rdata,

    // sampling
    input  wire                sample_start,
    input  wire   chan_t       sample_chan,
    output logic               sample_busy
);

    quad_t        status;
    timestamp_t   timestamp;
    sample_addr_t sample_raddr;
    quad_t        sample_rdata;
    sample_addr_t sample_waddr;
    quad_t        sample_wdata;
    logic         sample_we;
    block_addr_t  block_waddr;
    quad_t        block_wdata;
    logic         block_we;
    block_addr_t  block_raddr;
    quad_t        block_rdata;

    boot_config config0 (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .wenid        (wenid),
        .is_v30       (is_v30),
        .io1_in       (io1_in),
        .io1_out      (io1_out),
        .io1_oe       (io1_oe),
        .io2_in       (io2_in),
        .io2_out      (io2_out),
        .io2_oe       (io2_oe),
        .reg_raddr    (reg_raddr),
        .reg_waddr    (reg_waddr),
        .reg_wdata    (reg_wdata),
        .reg_wen      (reg_wen),
        .blk_wen      (blk_wen),
        .blk_wstart   (blk_wstart),
        .reg_rdata    (reg_rdata),
        .sample_busy  (sample_busy),
        .status       (status),
        .timestamp    (timestamp),
        .sample_raddr (sample_raddr),
        .sample_rdata (sample_rdata),
        .block_waddr  (block_waddr),
        .block_wdata  (block_wdata),
        .block_we     (block_we),
        .block_raddr  (block_raddr),
        .block_rdata  (block_rdata)
    );

    io_sampler sampler0 (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .sample_start (sample_start),
        .sample_chan  (sample_chan),
        .status       (status),
        .timestamp    (timestamp),
        .io1_in       (io1_in),
        .io2_in       (io2_in),
        .sample_busy  (sample_busy),
        .sample_waddr (sample_waddr),
        .sample_wdata (sample_wdata),
        .sample_we    (sample_we)
    );

    // snapshot buffer, written by the sampler
    quad_buffer #(
        .depth (`BCFG_SAMPLE_DEPTH)
    ) sample_buf0 (
        .sysclk (sysclk),
        .we     (sample_we),
        .waddr  (sample_waddr),
        .wdata  (sample_wdata),
        .raddr  (sample_raddr),
        .rdata  (sample_rdata)
    );

    // block write buffer, written from the host bus
    quad_buffer #(
        .depth (`BCFG_BLOCK_DEPTH)
    ) block_buf0 (
        .sysclk (sysclk),
        .we     (block_we),
        .waddr  (block_waddr),
        .wdata  (block_wdata),
        .raddr  (block_raddr),
        .rdata  (block_rdata)
    );

endmodule

`default_nettype wire

// ==== hw/board_pkg.sv ====
`default_nettype none

`include "bcfg_cfg.svh"

// board identity, connector I/O and status word
package board_pkg;

    typedef logic [3:0] board_id_t;                 // inverted rotary switch
    typedef logic [`BCFG_IO1_WIDTH-1:0] io1_t;      // J1
    typedef logic [`BCFG_IO2_WIDTH-1:0] io2_t;      // J2
    typedef logic [31:0] timestamp_t;               // cycles since reset

    // status word, msb first
    //   31:24 firmware version
    //   23:20 sample channel, only set in a snapshot
    //   15:8  block write count
    //   5     sample_busy
    //   4     is_v30
    //   3:0   board id
    typedef struct packed {
        logic [7:0] version;
        logic [3:0] chan;
        logic [3:0] rsvd_hi;
        logic [7:0] blk_cnt;
        logic [1:0] rsvd_lo;
        logic       sample_busy;
        logic       is_v30;
        board_id_t  board_id;
    } status_t;

endpackage

`default_nettype wire

// ==== hw/boot_config.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bcfg_cfg.svh"

// boot configuration register block
// board id, status, connector I/O regs, block write pointer, read mux
module boot_config
    import bus_pkg::*;
    import board_pkg::*;
(
    input  wire                sysclk,
    input  wire                rst_n,

    // board
    input  wire   board_id_t   wenid,         // rotary switch, active low
    input  wire                is_v30,

    // connector I/O
    input  wire   io1_t        io1_in,
    output io1_t               io1_out,
    output io1_t               io1_oe,
    input  wire   io2_t        io2_in,
    output io2_t               io2_out,
    output io2_t               io2_oe,

    // host register bus
    input  wire   reg_addr_t   reg_raddr,
    input  wire   reg_addr_t   reg_waddr,
    input  wire   quad_t       reg_wdata,
    input  wire                reg_wen,
    input  wire                blk_wen,
    input  wire                blk_wstart,
    output quad_t              reg_rdata,

    // sampler side
    input  wire                sample_busy,
    output quad_t              status,
    output timestamp_t         timestamp,
    output sample_addr_t       sample_raddr,
    input  wire   quad_t       sample_rdata,

    // block buffer
    output block_addr_t        block_waddr,
    output quad_t              block_wdata,
    output logic               block_we,
    output block_addr_t        block_raddr,
    input  wire   quad_t       block_rdata
);

    // read source, aligned with the buffer read ports
    typedef enum logic [1:0] {
        sel_none,
        sel_reg,
        sel_sample,
        sel_block
    } rd_sel_e;

    board_id_t  board_id;
    status_t    stat;
    logic [$clog2(`BCFG_BLOCK_DEPTH+1)-1:0] blk_ptr;   // reaches depth when full
    logic [3:0] rd_space;
    logic [11:0] rd_offs;
    logic [11:0] wr_offs;
    logic       reg_wr;
    quad_t      reg_value;
    quad_t      reg_data_q;
    rd_sel_e    rd_sel;
    rd_sel_e    rd_sel_q;

    assign board_id = ~wenid;

    // free running cycle count
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            timestamp <= '0;
        end else begin
            timestamp <= timestamp + 1'b1;
        end
    end

    always_comb begin
        stat             = '0;
        stat.version     = `BCFG_FW_VERSION;
        stat.blk_cnt     = 8'(blk_ptr);
        stat.sample_busy = sample_busy;
        stat.is_v30      = is_v30;
        stat.board_id    = board_id;
    end
    assign status = quad_t'(stat);

    // register writes, block writes take the bus instead
    assign wr_offs = reg_waddr[11:0];
    assign reg_wr  = reg_wen && !blk_wen && (reg_waddr[15:12] == `BCFG_SPACE_REG);

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            io1_out <= '0;
            io1_oe  <= '0;
            io2_out <= '0;
            io2_oe  <= '0;
        end else if (reg_wr) begin
            case (wr_offs)
                `BCFG_REG_IO1_OUT_LO: io1_out[31:0] <= reg_wdata;
                `BCFG_REG_IO1_OUT_HI:
                    io1_out[`BCFG_IO1_WIDTH-1:32] <= reg_wdata[`BCFG_IO1_WIDTH-33:0];
                `BCFG_REG_IO2_OUT_LO: io2_out[31:0] <= reg_wdata;
                `BCFG_REG_IO2_OUT_HI:
                    io2_out[`BCFG_IO2_WIDTH-1:32] <= reg_wdata[`BCFG_IO2_WIDTH-33:0];
                `BCFG_REG_IO1_OE_LO:  io1_oe[31:0] <= reg_wdata;
                `BCFG_REG_IO1_OE_HI:
                    io1_oe[`BCFG_IO1_WIDTH-1:32] <= reg_wdata[`BCFG_IO1_WIDTH-33:0];
                `BCFG_REG_IO2_OE_LO:  io2_oe[31:0] <= reg_wdata;
                `BCFG_REG_IO2_OE_HI:
                    io2_oe[`BCFG_IO2_WIDTH-1:32] <= reg_wdata[`BCFG_IO2_WIDTH-33:0];
                default: ;      // status, timestamp, inputs are read only
            endcase
        end
    end

    // block write pointer, saturating
    assign block_we    = reg_wen && blk_wen && (blk_ptr < `BCFG_BLOCK_DEPTH);
    assign block_waddr = block_addr_t'(blk_ptr);
    assign block_wdata = reg_wdata;

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            blk_ptr <= '0;
        end else if (blk_wstart) begin
            blk_ptr <= '0;
        end else if (block_we) begin
            blk_ptr <= blk_ptr + 1'b1;
        end
    end

    // read address decode
    assign rd_space     = reg_raddr[15:12];
    assign rd_offs      = reg_raddr[11:0];
    assign sample_raddr = sample_addr_t'(rd_offs);  // buffers see the address now
    assign block_raddr  = block_addr_t'(rd_offs);

    always_comb begin
        case (rd_offs)
            `BCFG_REG_STATUS:     reg_value = status;
            `BCFG_REG_TIMESTAMP:  reg_value = quad_t'(timestamp);
            `BCFG_REG_IO1_IN_LO:  reg_value = io1_in[31:0];
            `BCFG_REG_IO1_IN_HI:  reg_value = quad_t'(io1_in[`BCFG_IO1_WIDTH-1:32]);
            `BCFG_REG_IO2_IN_LO:  reg_value = io2_in[31:0];
            `BCFG_REG_IO2_IN_HI:  reg_value = quad_t'(io2_in[`BCFG_IO2_WIDTH-1:32]);
            `BCFG_REG_IO1_OUT_LO: reg_value = io1_out[31:0];
            `BCFG_REG_IO1_OUT_HI: reg_value = quad_t'(io1_out[`BCFG_IO1_WIDTH-1:32]);
            `BCFG_REG_IO2_OUT_LO: reg_value = io2_out[31:0];
            `BCFG_REG_IO2_OUT_HI: reg_value = quad_t'(io2_out[`BCFG_IO2_WIDTH-1:32]);
            `BCFG_REG_IO1_OE_LO:  reg_value = io1_oe[31:0];
            `BCFG_REG_IO1_OE_HI:  reg_value = quad_t'(io1_oe[`BCFG_IO1_WIDTH-1:32]);
            `BCFG_REG_IO2_OE_LO:  reg_value = io2_oe[31:0];
            `BCFG_REG_IO2_OE_HI:  reg_value = quad_t'(io2_oe[`BCFG_IO2_WIDTH-1:32]);
            default:              reg_value = '0;   // unmapped
        endcase
    end

    // out of range buffer offsets read as zero
    always_comb begin
        case (rd_space)
            `BCFG_SPACE_REG:    rd_sel = sel_reg;
            `BCFG_SPACE_SAMPLE:
                rd_sel = (rd_offs < `BCFG_SAMPLE_DEPTH) ? sel_sample : sel_none;
            `BCFG_SPACE_BLOCK:
                rd_sel = (rd_offs < `BCFG_BLOCK_DEPTH) ? sel_block : sel_none;
            default:            rd_sel = sel_none;
        endcase
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            rd_sel_q <= sel_none;     // reads zero out of reset
        end else begin
            rd_sel_q <= rd_sel;
        end
    end

    always_ff @(posedge sysclk) begin
        reg_data_q <= reg_value;
    end

    // same 1 cycle latency for every space
    always_comb begin
        case (rd_sel_q)
            sel_reg:    reg_rdata = reg_data_q;
            sel_sample: reg_rdata = sample_rdata;
            sel_block:  reg_rdata = block_rdata;
            default:    reg_rdata = '0;
        endcase
    end

    // pointer stays at depth once full, until the next start
    ap_blk_ptr_range: assert property (@(posedge sysclk) disable iff (!rst_n)
        blk_ptr <= `BCFG_BLOCK_DEPTH)
        else $error("block pointer past buffer depth");

    // host never starts a block in a write cycle
    ap_wstart_wen: assert property (@(posedge sysclk) disable iff (!rst_n)
        !(reg_wen && blk_wstart))
        else $error("blk_wstart together with reg_wen");

endmodule

`default_nettype wire

// ==== hw/bus_pkg.sv ====
`default_nettype none

`include "bcfg_cfg.svh"

// host register bus types
package bus_pkg;

    // space code in 15:12, offset in 11:0
    typedef logic [15:0] reg_addr_t;

    typedef logic [31:0] quad_t;    // one bus word

    // buffer addresses, sized from the depths
    typedef logic [$clog2(`BCFG_SAMPLE_DEPTH)-1:0] sample_addr_t;
    typedef logic [$clog2(`BCFG_BLOCK_DEPTH)-1:0]  block_addr_t;

    typedef logic [3:0] chan_t;     // sample channel tag

endpackage

`default_nettype wire

// ==== hw/io_sampler.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bcfg_cfg.svh"

// snapshot sequencer
// timestamp, status and I/O inputs into the sample buffer
module io_sampler
    import bus_pkg::*;
    import board_pkg::*;
(
    input  wire                sysclk,
    input  wire                rst_n,

    input  wire                sample_start,  // pulse
    input  wire   chan_t       sample_chan,
    input  wire   quad_t       status,        // live status word
    input  wire   timestamp_t  timestamp,
    input  wire   io1_t        io1_in,
    input  wire   io2_t        io2_in,

    output logic               sample_busy,

    // sample buffer write port
    output sample_addr_t       sample_waddr,
    output quad_t              sample_wdata,
    output logic               sample_we
);

    sample_addr_t cnt;          // quadlet being written
    timestamp_t   ts_q;         // time of the start pulse
    chan_t        chan_q;
    status_t      snap_stat;
    logic         start_ok;

    assign start_ok = sample_start && !sample_busy;    // start while busy is dropped

    // sequencer
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            sample_busy <= 1'b0;
            cnt         <= '0;
        end else if (!sample_busy) begin
            if (start_ok) begin
                sample_busy <= 1'b1;
                cnt         <= '0;
            end
        end else begin
            cnt <= cnt + 1'b1;
            // last quadlet goes out this cycle
            if (cnt == sample_addr_t'(`BCFG_SAMPLE_QUADS - 1)) begin
                sample_busy <= 1'b0;
            end
        end
    end

    // latched at the edge that sees the start
    always_ff @(posedge sysclk) begin
        if (start_ok) begin
            ts_q   <= timestamp;
            chan_q <= sample_chan;
        end
    end

    // status with channel tag
    always_comb begin
        snap_stat      = status_t'(status);
        snap_stat.chan = chan_q;
    end

    // one quadlet per busy cycle
    always_comb begin
        case (cnt)
            'd0:     sample_wdata = quad_t'(ts_q);
            'd1:     sample_wdata = quad_t'(snap_stat);
            'd2:     sample_wdata = io1_in[31:0];
            'd3:     sample_wdata = quad_t'(io1_in[`BCFG_IO1_WIDTH-1:32]);  // zero ext
            'd4:     sample_wdata = io2_in[31:0];
            'd5:     sample_wdata = quad_t'(io2_in[`BCFG_IO2_WIDTH-1:32]);
            default: sample_wdata = '0;
        endcase
    end

    assign sample_waddr = cnt;
    assign sample_we    = sample_busy;

    // writes stay inside one snapshot
    ap_we_in_snap: assert property (@(posedge sysclk) disable iff (!rst_n)
        sample_we |-> sample_waddr < sample_addr_t'(`BCFG_SAMPLE_QUADS))
        else $error("sample write past the end of the snapshot");

    // busy lasts exactly one snapshot
    ap_busy_len: assert property (@(posedge sysclk) disable iff (!rst_n)
        $rose(sample_busy) |-> sample_busy [*`BCFG_SAMPLE_QUADS] ##1 !sample_busy)
        else $error("sample_busy length wrong");

endmodule

`default_nettype wire

// ==== hw/quad_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

// quadlet memory
// one write port, registered read port
module quad_buffer
    import bus_pkg::*;
#(
    parameter int depth = 8
) (
    input  wire                       sysclk,
    input  wire                       we,
    input  wire  [$clog2(depth)-1:0]  waddr,
    input  wire  quad_t               wdata,
    input  wire  [$clog2(depth)-1:0]  raddr,
    output quad_t                     rdata
);

    quad_t mem [depth];     // contents come up undefined

    // write side
    always_ff @(posedge sysclk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read side, 1 cycle latency
    // same address write in the same cycle returns old data
    always_ff @(posedge sysclk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// ==== include/bcfg_cfg.svh ====
`ifndef BCFG_CFG_SVH
`define BCFG_CFG_SVH

// connector banks J1 and J2
`define BCFG_IO1_WIDTH      34
`define BCFG_IO2_WIDTH      40

// buffers
`define BCFG_SAMPLE_QUADS   6       // quadlets per snapshot
`define BCFG_SAMPLE_DEPTH   8
`define BCFG_BLOCK_DEPTH    16

`define BCFG_FW_VERSION     8'h31

// address space code in reg address bits 15:12
`define BCFG_SPACE_REG      4'h0
`define BCFG_SPACE_SAMPLE   4'h1
`define BCFG_SPACE_BLOCK    4'h2

// offsets in register space, bits 11:0
`define BCFG_REG_STATUS     12'h000 // read only
`define BCFG_REG_TIMESTAMP  12'h001 // read only
`define BCFG_REG_IO1_IN_LO  12'h004
`define BCFG_REG_IO1_IN_HI  12'h005
`define BCFG_REG_IO2_IN_LO  12'h006
`define BCFG_REG_IO2_IN_HI  12'h007
`define BCFG_REG_IO1_OUT_LO 12'h008
`define BCFG_REG_IO1_OUT_HI 12'h009
`define BCFG_REG_IO2_OUT_LO 12'h00a
`define BCFG_REG_IO2_OUT_HI 12'h00b
`define BCFG_REG_IO1_OE_LO  12'h00c
`define BCFG_REG_IO1_OE_HI  12'h00d
`define BCFG_REG_IO2_OE_LO  12'h00e
`define BCFG_REG_IO2_OE_HI  12'h00f

`endif

// ==== sources.f ====
+incdir+include
hw/bus_pkg.sv
hw/board_pkg.sv
hw/quad_buffer.sv
hw/io_sampler.sv
hw/boot_config.sv
hw/bcfg_top.sv
verif/tb_bcfg.sv

// ==== verif/tb_bcfg.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bcfg_cfg.svh"

// testbench for the boot configuration subsystem
module tb_bcfg
    import bus_pkg::*;
    import board_pkg::*;
();

    typedef enum logic [2:0] {
        op_write,
        op_bstart,
        op_bwrite,
        op_sample,
        op_wait_idle,
        op_read
    } op_e;

    // one table row, outputs expected after the row
    typedef struct packed {
        op_e        op;
        logic [1:0] mode;   // timestamp role, 1 first, 2 second
        reg_addr_t  addr;
        quad_t      data;
        io1_t       io1;
        io2_t       io2;
        quad_t      exp;
        io1_t       o1;
        io1_t       e1;
        io2_t       o2;
        io2_t       e2;
    } entry_t;

    logic       sysclk;
    logic       rst_n;
    board_id_t  wenid;
    logic       is_v30;
    io1_t       io1_in;
    io1_t       io1_out;
    io1_t       io1_oe;
    io2_t       io2_in;
    io2_t       io2_out;
    io2_t       io2_oe;
    reg_addr_t  reg_raddr;
    reg_addr_t  reg_waddr;
    quad_t      reg_wdata;
    logic       reg_wen;
    logic       blk_wen;
    logic       blk_wstart;
    quad_t      reg_rdata;
    logic       sample_start;
    chan_t      sample_chan;
    logic       sample_busy;

    entry_t     tab [$];
    logic [31:0] rng = 32'h1799;
    io1_t       cur_io1;            // pattern on the pins
    io2_t       cur_io2;
    io1_t       m_o1;               // model of the output regs
    io1_t       m_e1;
    io2_t       m_o2;
    io2_t       m_e2;
    int         m_blk;              // block quadlets written
    int         cyc = 0;
    int         cyc_limit = 100;
    int         busy_run = 0;
    int         busy_len = 0;       // length of last busy window
    int         cyc_a;
    int         cyc_b;
    quad_t      ts_first;

    bcfg_top dut0 (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .wenid        (wenid),
        .is_v30       (is_v30),
        .io1_in       (io1_in),
        .io1_out      (io1_out),
        .io1_oe       (io1_oe),
        .io2_in       (io2_in),
        .io2_out      (io2_out),
        .io2_oe       (io2_oe),
        .reg_raddr    (reg_raddr),
        .reg_waddr    (reg_waddr),
        .reg_wdata    (reg_wdata),
        .reg_wen      (reg_wen),
        .blk_wen      (blk_wen),
        .blk_wstart   (blk_wstart),
        .reg_rdata    (reg_rdata),
        .sample_start (sample_start),
        .sample_chan  (sample_chan),
        .sample_busy  (sample_busy)
    );

    initial begin
        sysclk = 1'b0;
        forever #5 sysclk = ~sysclk;
    end

    always @(posedge sysclk) begin
        cyc = cyc + 1;
        if (cyc > cyc_limit) begin
            $display("timeout: run did not finish within %0d cycles", cyc_limit);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

    // busy window length, sampled mid cycle
    always @(negedge sysclk) begin
        if (!rst_n) begin
            busy_run = 0;
        end else if (sample_busy === 1'b1) begin
            busy_run = busy_run + 1;
        end else if (busy_run != 0) begin
            busy_len = busy_run;
            busy_run = 0;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw(output quad_t r);
        rng = xorshift32(rng);
        r = rng;
    endtask

    task automatic new_pattern();
        quad_t a;
        quad_t b;
        quad_t c;
        quad_t d;
        draw(a);
        draw(b);
        draw(c);
        draw(d);
        cur_io1 = io1_t'({b, a});   // upper bits dropped
        cur_io2 = io2_t'({d, c});
    endtask

    // layout 31:24 version, 23:20 chan, 15:8 count, 5 busy, 4 v30, 3:0 id
    function automatic quad_t status_word(input chan_t chan, input int blk, input logic busy);
        return {`BCFG_FW_VERSION, chan, 4'h0, blk[7:0], 2'b00, busy, is_v30, ~wenid};
    endfunction

    function automatic reg_addr_t map_addr(input logic [3:0] space, input logic [11:0] offs);
        return {space, offs};
    endfunction

    function automatic quad_t out_reg_expect(input logic [11:0] offs);
        case (offs)
            `BCFG_REG_IO1_OUT_LO: return m_o1[31:0];
            `BCFG_REG_IO1_OUT_HI: return quad_t'(m_o1 >> 32);
            `BCFG_REG_IO2_OUT_LO: return m_o2[31:0];
            `BCFG_REG_IO2_OUT_HI: return quad_t'(m_o2 >> 32);
            `BCFG_REG_IO1_OE_LO:  return m_e1[31:0];
            `BCFG_REG_IO1_OE_HI:  return quad_t'(m_e1 >> 32);
            `BCFG_REG_IO2_OE_LO:  return m_e2[31:0];
            `BCFG_REG_IO2_OE_HI:  return quad_t'(m_e2 >> 32);
            default:              return '0;
        endcase
    endfunction

    task automatic add_entry(input op_e op, input reg_addr_t addr, input quad_t data,
                             input quad_t exp, input logic [1:0] mode);
        entry_t e;
        e.op   = op;
        e.mode = mode;
        e.addr = addr;
        e.data = data;
        e.io1  = cur_io1;
        e.io2  = cur_io2;
        e.exp  = exp;
        e.o1   = m_o1;
        e.e1   = m_e1;
        e.o2   = m_o2;
        e.e2   = m_e2;
        tab.push_back(e);
    endtask

    task automatic add_read(input reg_addr_t addr, input quad_t exp);
        add_entry(op_read, addr, '0, exp, 2'd0);
    endtask

    // high words keep only the bank's width
    task automatic add_write(input reg_addr_t addr, input quad_t data);
        if (addr[15:12] == `BCFG_SPACE_REG) begin
            case (addr[11:0])
                `BCFG_REG_IO1_OUT_LO: m_o1[31:0] = data;
                `BCFG_REG_IO1_OUT_HI: m_o1 = io1_t'({data, m_o1[31:0]});
                `BCFG_REG_IO2_OUT_LO: m_o2[31:0] = data;
                `BCFG_REG_IO2_OUT_HI: m_o2 = io2_t'({data, m_o2[31:0]});
                `BCFG_REG_IO1_OE_LO:  m_e1[31:0] = data;
                `BCFG_REG_IO1_OE_HI:  m_e1 = io1_t'({data, m_e1[31:0]});
                `BCFG_REG_IO2_OE_LO:  m_e2[31:0] = data;
                `BCFG_REG_IO2_OE_HI:  m_e2 = io2_t'({data, m_e2[31:0]});
                default: ;
            endcase
        end
        add_entry(op_write, addr, data, '0, 2'd0);
    endtask

    // the four input words of the current pattern from one space
    task automatic add_input_reads(input logic [3:0] space, input logic [11:0] base);
        add_read(map_addr(space, base), cur_io1[31:0]);
        add_read(map_addr(space, base + 12'd1), quad_t'(cur_io1 >> 32));
        add_read(map_addr(space, base + 12'd2), cur_io2[31:0]);
        add_read(map_addr(space, base + 12'd3), quad_t'(cur_io2 >> 32));
    endtask

    task automatic build_table();
        quad_t r;
        quad_t blk_data [5];
        draw(r);
        wenid  = r[3:0];
        is_v30 = r[4];
        m_o1 = '0;
        m_e1 = '0;
        m_o2 = '0;
        m_e2 = '0;
        m_blk = 0;
        new_pattern();
        // reset state
        add_read(map_addr(`BCFG_SPACE_REG, `BCFG_REG_STATUS), status_word(4'h0, 0, 1'b0));
        for (int i = 8; i < 16; i++) begin
            add_read(map_addr(`BCFG_SPACE_REG, 12'(i)), '0);
        end
        // inputs, new pattern on every read
        for (int i = 4; i < 8; i++) begin
            new_pattern();
            add_read(map_addr(`BCFG_SPACE_REG, 12'(i)), (i[0] ? quad_t'((i < 6 ? {6'b0, cur_io1} :
                     cur_io2) >> 32) : (i < 6 ? cur_io1[31:0] : cur_io2[31:0])));
        end
        for (int i = 8; i < 16; i++) begin
            draw(r);
            add_write(map_addr(`BCFG_SPACE_REG, 12'(i)), r);
        end
        for (int i = 8; i < 16; i++) begin
            add_read(map_addr(`BCFG_SPACE_REG, 12'(i)), out_reg_expect(12'(i)));
        end
        // block write of five quadlets
        add_entry(op_bstart, '0, '0, '0, 2'd0);
        for (int i = 0; i < 5; i++) begin
            draw(blk_data[i]);
            add_entry(op_bwrite, map_addr(`BCFG_SPACE_BLOCK, 12'(i)), blk_data[i], '0, 2'd0);
            m_blk++;
        end
        for (int i = 0; i < 5; i++) begin
            add_read(map_addr(`BCFG_SPACE_BLOCK, 12'(i)), blk_data[i]);
        end
        add_read(map_addr(`BCFG_SPACE_REG, `BCFG_REG_STATUS), status_word(4'h0, m_blk, 1'b0));
        // first snapshot
        new_pattern();
        add_entry(op_sample, '0, 32'h3, '0, 2'd1);
        add_entry(op_wait_idle, '0, '0, `BCFG_SAMPLE_QUADS, 2'd0);
        add_entry(op_read, map_addr(`BCFG_SPACE_SAMPLE, 12'h0), '0, '0, 2'd1);
        add_read(map_addr(`BCFG_SPACE_SAMPLE, 12'h1), status_word(4'h3, m_blk, 1'b1));
        add_input_reads(`BCFG_SPACE_SAMPLE, 12'h2);
        // unmapped reads and read only writes
        add_read(map_addr(`BCFG_SPACE_REG, 12'h002), '0);
        add_read(map_addr(`BCFG_SPACE_REG, 12'h003), '0);
        add_read(map_addr(`BCFG_SPACE_REG, 12'h010), '0);
        add_read(map_addr(4'h3, 12'h000), '0);
        add_read(map_addr(`BCFG_SPACE_SAMPLE, 12'h008), '0);
        add_write(map_addr(`BCFG_SPACE_REG, `BCFG_REG_STATUS), 32'hffff_ffff);
        add_write(map_addr(`BCFG_SPACE_REG, `BCFG_REG_IO1_IN_LO), 32'h5a5a_5a5a);
        add_read(map_addr(`BCFG_SPACE_REG, `BCFG_REG_STATUS), status_word(4'h0, m_blk, 1'b0));
        add_input_reads(`BCFG_SPACE_REG, `BCFG_REG_IO1_IN_LO);
        // second snapshot, the start while busy must be dropped
        new_pattern();
        add_entry(op_sample, '0, 32'h5, '0, 2'd2);
        add_entry(op_sample, '0, 32'h9, '0, 2'd0);
        add_entry(op_wait_idle, '0, '0, `BCFG_SAMPLE_QUADS, 2'd0);
        add_entry(op_read, map_addr(`BCFG_SPACE_SAMPLE, 12'h0), '0, '0, 2'd2);
        add_read(map_addr(`BCFG_SPACE_SAMPLE, 12'h1), status_word(4'h5, m_blk, 1'b1));
        add_input_reads(`BCFG_SPACE_SAMPLE, 12'h2);
    endtask

    task automatic stop_with(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic compare_quad(input string name, input quad_t act, input quad_t exp);
        if (act !== exp) begin
            stop_with($sformatf("error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic compare_io1(input string name, input io1_t act, input io1_t exp);
        if (act !== exp) begin
            stop_with($sformatf("error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic compare_io2(input string name, input io2_t act, input io2_t exp);
        if (act !== exp) begin
            stop_with($sformatf("error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    // every row starts 1 ns after a rising edge and ends there
    task automatic run_entry(input entry_t e);
        io1_in = e.io1;
        io2_in = e.io2;
        case (e.op)
            op_write, op_bwrite: begin
                reg_waddr = e.addr;
                reg_wdata = e.data;
                reg_wen   = 1'b1;
                blk_wen   = (e.op == op_bwrite);
                @(posedge sysclk);
                #1;
                reg_wen = 1'b0;
                blk_wen = 1'b0;
            end
            op_bstart: begin
                blk_wstart = 1'b1;
                @(posedge sysclk);
                #1;
                blk_wstart = 1'b0;
            end
            op_sample: begin
                sample_start = 1'b1;
                sample_chan  = e.data[3:0];
                @(posedge sysclk);
                #1;
                sample_start = 1'b0;
                if (e.mode == 2'd1) cyc_a = cyc;    // edge that saw the start
                if (e.mode == 2'd2) cyc_b = cyc;
            end
            op_wait_idle: begin
                while (sample_busy === 1'b1) begin
                    @(posedge sysclk);
                    #1;
                end
                @(posedge sysclk);      // lets the monitor close the window
                #1;
                compare_quad("sample_busy cycles", quad_t'(busy_len), e.exp);
            end
            default: begin
                reg_raddr = e.addr;
                @(posedge sysclk);
                #1;
                if (e.mode == 2'd1) begin
                    ts_first = reg_rdata;
                end else if (e.mode == 2'd2) begin
                    compare_quad("timestamp delta", reg_rdata - ts_first, quad_t'(cyc_b - cyc_a));
                end else begin
                    compare_quad($sformatf("reg_rdata @%h", e.addr), reg_rdata, e.exp);
                end
            end
        endcase
        compare_io1("io1_out", io1_out, e.o1);
        compare_io1("io1_oe", io1_oe, e.e1);
        compare_io2("io2_out", io2_out, e.o2);
        compare_io2("io2_oe", io2_oe, e.e2);
    endtask

    initial begin
        rst_n        = 1'b0;
        wenid        = '0;
        is_v30       = 1'b0;
        io1_in       = '0;
        io2_in       = '0;
        reg_raddr    = '0;
        reg_waddr    = '0;
        reg_wdata    = '0;
        reg_wen      = 1'b0;
        blk_wen      = 1'b0;
        blk_wstart   = 1'b0;
        sample_start = 1'b0;
        sample_chan  = '0;
        build_table();
        cyc_limit = tab.size() * 10 + 100;
        repeat (5) @(posedge sysclk);
        #1;
        rst_n = 1'b1;
        if (sample_busy !== 1'b0) begin
            stop_with("sample_busy is not low after reset");
        end
        compare_quad("reg_rdata", reg_rdata, '0);
        foreach (tab[i]) begin
            run_entry(tab[i]);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire
